// File: include/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// bus dimensions
`define N_MASTERS   3   // masters sharing the memory
`define ADDR_W      4   // 16 memory words
`define DATA_W      16  // bus data width

// extra cycles before the acknowledge, one or more
`define WAIT_STATES 2

`endif

// File: src/bus_pkg.sv
`include "bus_settings.svh"

package bus_pkg;

    // one bit per master, for request, grant and acknowledge
    typedef logic [`N_MASTERS-1:0] arb_vector_t;

    // memory word address
    typedef logic [`ADDR_W-1:0] addr_t;

    // bus data word
    typedef logic [`DATA_W-1:0] data_t;

    // arbiter control states
    typedef enum logic {
        READY = 1'b0,  // bus idle, waiting for requests
        BUSY  = 1'b1   // a master owns the bus
    } arb_state_t;

endpackage

// File: src/bus_arbiter.sv
`timescale 1ns/1ps
`include "bus_settings.svh"

module bus_arbiter
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        bus_ack,
    input  arb_vector_t bus_req,
    output arb_vector_t bus_grant
);

    arb_state_t  state;
    arb_vector_t req_masked;  // requests that take part in the next decision
    arb_vector_t prio_req;    // lowest-index request, one-hot or zero

    // the holder still requests during its acknowledge, so leave it out
    assign req_masked = bus_ack ? (bus_req & ~bus_grant) : bus_req;

    // fixed priority, index 0 wins
    always_comb begin
        logic found;
        found    = 1'b0;
        prio_req = '0;
        for (int i = 0; i < `N_MASTERS; i++) begin
            if (!found && req_masked[i]) begin
                prio_req[i] = 1'b1;
                found       = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= READY;
            bus_grant <= '0;
        end else begin
            case (state)
                READY: begin
                    bus_grant <= prio_req;  // zero when nobody asks
                    if (req_masked != '0) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    // grant holds until the slave ends the tenure
                    if (bus_ack) begin
                        bus_grant <= prio_req;
                        if (req_masked != '0) begin
                            state <= BUSY;  // hand over directly
                        end else begin
                            state <= READY;
                        end
                    end
                end
                default: begin
                    state     <= READY;
                    bus_grant <= '0;
                end
            endcase
        end
    end

    // at most one owner at any time
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(bus_grant)
    );

    // no change of owner before the slave acknowledges
    a_grant_stable: assert property (
        @(posedge clk) disable iff (reset)
        (bus_grant != '0) && !bus_ack |=> $stable(bus_grant)
    );

    // a new owner asked for the bus, and no lower index was waiting
    // apart from the master that just finished
    for (genvar i = 0; i < `N_MASTERS; i++) begin : g_rise_chk
        localparam arb_vector_t LOWER = arb_vector_t'((1 << i) - 1);

        a_grant_prio: assert property (
            @(posedge clk) disable iff (reset)
            $rose(bus_grant[i]) |->
                $past(bus_req[i]) &&
                (($past(bus_req) & ~$past(bus_grant) & LOWER) == '0)
        );
    end

endmodule

// File: src/bus_slave_mem.sv
`timescale 1ns/1ps
`include "bus_settings.svh"

module bus_slave_mem
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  arb_vector_t bus_grant,
    input  addr_t       m_addr [`N_MASTERS],
    input  data_t       m_wdata [`N_MASTERS],
    input  logic        m_we [`N_MASTERS],
    output logic        bus_ack,
    output arb_vector_t m_ack,
    output data_t       rdata
);

    localparam int DEPTH = 1 << `ADDR_W;
    localparam int CNT_W = $clog2(`WAIT_STATES + 1);
    localparam logic [CNT_W-1:0] LAST_WAIT = CNT_W'(`WAIT_STATES - 1);

    addr_t            sel_addr;   // granted master's fields
    data_t            sel_wdata;
    logic             sel_we;
    logic             granted;
    logic             ack_next;
    logic [CNT_W-1:0] wait_cnt;   // cycles spent in the current grant
    data_t            mem [DEPTH];

    // AND-OR select, the grant is one-hot or zero
    always_comb begin
        sel_addr  = '0;
        sel_wdata = '0;
        sel_we    = 1'b0;
        for (int i = 0; i < `N_MASTERS; i++) begin
            sel_addr  = sel_addr | (m_addr[i] & {`ADDR_W{bus_grant[i]}});
            sel_wdata = sel_wdata | (m_wdata[i] & {`DATA_W{bus_grant[i]}});
            sel_we    = sel_we | (m_we[i] & bus_grant[i]);
        end
    end

    assign granted = (bus_grant != '0);

    // acknowledge comes in grant cycle WAIT_STATES+1
    assign ack_next = granted && (wait_cnt == LAST_WAIT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
            bus_ack  <= 1'b0;
        end else begin
            bus_ack <= ack_next;
            if (bus_ack || !granted) begin
                wait_cnt <= '0;  // next grant counts from zero
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // read word is captured on the edge that raises the acknowledge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdata <= '0;
        end else if (ack_next && !sel_we) begin
            rdata <= mem[sel_addr];
        end
    end

    // write lands at the end of the acknowledge cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (bus_ack && sel_we) begin
            mem[sel_addr] <= sel_wdata;
        end
    end

    // only the owner sees the acknowledge
    assign m_ack = bus_grant & {`N_MASTERS{bus_ack}};

    // the arbiter must still hold the grant when the acknowledge arrives
    a_ack_granted: assert property (
        @(posedge clk) disable iff (reset)
        bus_ack |-> granted
    );

    // one pulse per tenure
    a_ack_pulse: assert property (
        @(posedge clk) disable iff (reset)
        bus_ack |=> !bus_ack
    );

endmodule

// File: src/shared_bus_top.sv
`timescale 1ns/1ps
`include "bus_settings.svh"

module shared_bus_top
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  arb_vector_t bus_req,
    input  addr_t       m_addr [`N_MASTERS],
    input  data_t       m_wdata [`N_MASTERS],
    input  logic        m_we [`N_MASTERS],
    output arb_vector_t bus_grant,
    output arb_vector_t m_ack,
    output data_t       rdata
);

    logic bus_ack;  // end of tenure, slave to arbiter

    bus_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req),
        .bus_grant (bus_grant)
    );

    // grant also steers the slave select
    bus_slave_mem u_slave (
        .clk       (clk),
        .reset     (reset),
        .bus_grant (bus_grant),
        .m_addr    (m_addr),
        .m_wdata   (m_wdata),
        .m_we      (m_we),
        .bus_ack   (bus_ack),
        .m_ack     (m_ack),
        .rdata     (rdata)
    );

endmodule

// File: dv/tb_shared_bus.sv
`timescale 1ns/1ps
`include "bus_settings.svh"

module tb_shared_bus
    import bus_pkg::*;
();

    localparam int MAX_TRANS = 64;
    localparam int FIELDS    = 5;  // phase, master, we, addr, data

    logic        clk;
    logic        reset;
    arb_vector_t bus_req;
    addr_t       m_addr [`N_MASTERS];
    data_t       m_wdata [`N_MASTERS];
    logic        m_we [`N_MASTERS];
    arb_vector_t bus_grant;
    arb_vector_t m_ack;
    data_t       rdata;

    logic [`DATA_W-1:0] raw [MAX_TRANS*FIELDS];
    int          t_phase [MAX_TRANS];
    int          t_master [MAX_TRANS];
    logic        t_we [MAX_TRANS];
    addr_t       t_addr [MAX_TRANS];
    data_t       t_data [MAX_TRANS];
    int          n_trans;
    int          last_phase;
    int          cycle_limit;
    int          cycles = 0;
    arb_vector_t exp_acks [$];  // acknowledge order still expected in this phase

    shared_bus_top DUT (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .m_addr    (m_addr),
        .m_wdata   (m_wdata),
        .m_we      (m_we),
        .bus_grant (bus_grant),
        .m_ack     (m_ack),
        .rdata     (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_grant(input string name, input arb_vector_t exp,
                               input arb_vector_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic load_testdata();
        int   k;
        logic at_end;
        at_end     = 1'b0;
        n_trans    = 0;
        last_phase = 0;
        $readmemh("dv/shared_bus_testdata.txt", raw);
        for (int n = 0; n < MAX_TRANS; n++) begin
            k = n * FIELDS;
            if (raw[k] == 16'h00ff) begin
                at_end = 1'b1;
                break;
            end
            t_phase[n]  = int'(raw[k]);
            t_master[n] = int'(raw[k+1]);
            t_we[n]     = raw[k+2][0];
            t_addr[n]   = addr_t'(raw[k+3]);
            t_data[n]   = raw[k+4];
            if (t_master[n] >= `N_MASTERS) begin
                $display("test data line %0d names a master that does not exist", n);
                abort_run();
            end
            if (t_phase[n] > last_phase) begin
                last_phase = t_phase[n];
            end
            n_trans++;
        end
        if (!at_end || n_trans == 0) begin
            $display("test data file is missing, empty or has no end marker");
            abort_run();
        end
        cycle_limit = n_trans * `N_MASTERS * (`WAIT_STATES + 3) + 100;
    endtask

    // every master with work left is requesting again at each handover,
    // so the finished master goes last unless nobody else is waiting
    function automatic void predict_acks(input int ph);
        int left [`N_MASTERS];
        int total;
        int last;
        int next;
        total = 0;
        last  = -1;
        exp_acks.delete();
        for (int m = 0; m < `N_MASTERS; m++) begin
            left[m] = 0;
        end
        for (int i = 0; i < n_trans; i++) begin
            if (t_phase[i] == ph) begin
                left[t_master[i]]++;
                total++;
            end
        end
        repeat (total) begin
            next = -1;
            for (int m = 0; m < `N_MASTERS; m++) begin
                if (next < 0 && left[m] > 0 && m != last) begin
                    next = m;
                end
            end
            if (next < 0) begin
                next = last;
            end
            left[next]--;
            exp_acks.push_back(arb_vector_t'(1) << next);
            last = next;
        end
    endfunction

    task automatic play_master(input int m, input int ph);
        for (int i = 0; i < n_trans; i++) begin
            if (t_phase[i] == ph && t_master[i] == m) begin
                @(posedge clk);
                bus_req[m] <= 1'b1;
                m_we[m]    <= t_we[i];
                m_addr[m]  <= t_addr[i];
                m_wdata[m] <= t_we[i] ? t_data[i] : '0;
                do begin
                    @(posedge clk);
                end while (m_ack[m] !== 1'b1);
                if (!t_we[i]) begin
                    check_data($sformatf("phase %0d master %0d read %0h", ph, m, t_addr[i]),
                               t_data[i], rdata);
                end
                bus_req[m] <= 1'b0;  // low for at least one cycle
            end
        end
    endtask

    task automatic run_phase(input int ph);
        fork
            play_master(0, ph);
            play_master(1, ph);
            play_master(2, ph);
        join
    endtask

    // grant legality and acknowledge order, every cycle
    always @(posedge clk) begin
        arb_vector_t held;
        if (!reset) begin
            held = bus_grant & bus_req;
            held = held & ~(held - 1'b1);  // lowest requested grant bit
            check_grant("grant legality", held, bus_grant);
            if (m_ack != '0) begin
                if (exp_acks.size() == 0) begin
                    $display("an acknowledge arrived that no master was waiting for");
                    abort_run();
                end else begin
                    check_grant("acknowledge order", exp_acks.pop_front(), m_ack);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, the tests did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        int gap;
        void'($urandom(74840));
        reset   = 1'b1;
        bus_req = '0;
        for (int m = 0; m < `N_MASTERS; m++) begin
            m_addr[m]  = '0;
            m_wdata[m] = '0;
            m_we[m]    = 1'b0;
        end
        load_testdata();

        @(posedge clk);
        repeat (3) begin
            @(posedge clk);
            check_grant("grant in reset", '0, bus_grant);
            check_grant("m_ack in reset", '0, m_ack);
            check_data("rdata in reset", '0, rdata);
        end
        reset <= 1'b0;
        @(posedge clk);
        check_grant("grant after reset", '0, bus_grant);
        check_grant("m_ack after reset", '0, m_ack);
        check_data("rdata after reset", '0, rdata);

        for (int ph = 0; ph <= last_phase; ph++) begin
            predict_acks(ph);
            run_phase(ph);
            @(posedge clk);  // let the monitor take the last acknowledge
            if (exp_acks.size() != 0) begin
                $display("phase %0d ended with acknowledges still missing", ph);
                abort_run();
            end
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge clk);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
src/bus_pkg.sv
src/bus_arbiter.sv
src/bus_slave_mem.sv
src/shared_bus_top.sv
dv/tb_shared_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the shared bus testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_shared_bus -f build.f \
    && ./obj_dir/Vtb_shared_bus | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run_sim: test run passed" \
    || { echo "run_sim: test run failed"; exit 1; }

// File: dv/shared_bus_testdata.txt
// each line holds phase master we addr data in hex
// data is the write word when we is 1 and the expected read word when we is 0
// phase 0 master 0 writes then reads back, 5 and 0 were never written
00 0 1 1 1234
00 0 1 2 beef
00 0 1 3 0f0f
00 0 0 1 1234
00 0 0 2 beef
00 0 0 3 0f0f
00 0 0 5 0000
00 0 0 0 0000
// phase 1 all three masters at once
01 0 1 6 1111
01 1 1 7 2222
01 2 0 1 1234
// phase 2 master 0 has two transactions and master 1 has one
02 0 1 8 3333
02 0 0 8 3333
02 1 0 6 1111
// phase 3 master 2 writes
03 2 1 9 a001
03 2 1 a a002
03 2 1 f a00f
// phase 4 master 1 reads what master 2 wrote
04 1 0 9 a001
04 1 0 a a002
04 1 0 f a00f
04 0 0 7 2222
// end marker
ff 0 0 0 0000
